// File: bpu.f
+incdir+source
source/bpu_pkg.sv
source/btb_bank_ram.sv
source/btb.sv
source/bimodal_table.sv
source/pred_select.sv
source/bpu_top.sv
tests/bpu_tb.sv

// File: Bender.yml
package:
  name: bpu

sources:
  - include_dirs:
      - source
    files:
      - source/bpu_pkg.sv
      - source/btb_bank_ram.sv
      - source/btb.sv
      - source/bimodal_table.sv
      - source/pred_select.sv
      - source/bpu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/bpu_tb.sv

// File: tests/bpu_tb.sv
`timescale 1ns/1ps
`include "bpu_settings.svh"

module bpu_tb;

    typedef struct packed {
        logic                   stall;
        logic [`BPU_ADDR_W-1:0] pc;
        logic                   update;
        logic [`BPU_ADDR_W-1:0] update_pc;
        logic                   update_taken;
        bpu_pkg::br_kind_e      update_kind;
        logic [`BPU_ADDR_W-1:0] update_target;
    } row_t;

    localparam int MAX_ROWS    = 320;
    localparam int RAND_ROWS   = 200;
    localparam int RST_TIMEOUT = 20;

    localparam logic [31:0] PC_A     = 32'h0000_1000;
    localparam logic [31:0] PC_C     = 32'h0000_1004;
    localparam logic [31:0] PC_D     = 32'h0000_1008;
    localparam logic [31:0] PC_B     = 32'h0000_1010;
    localparam logic [31:0] PC_ALIAS = 32'h0000_2000;

    logic                   clk;
    logic                   rst;
    logic                   stall;
    logic [`BPU_ADDR_W-1:0] pc;
    logic                   update;
    logic [`BPU_ADDR_W-1:0] update_pc;
    logic                   update_taken;
    bpu_pkg::br_kind_e      update_kind;
    logic [`BPU_ADDR_W-1:0] update_target;
    logic                   pred_hit;
    logic                   pred_taken;
    logic [`BPU_ADDR_W-1:0] next_pc;

    row_t rows [MAX_ROWS];
    row_t cur;
    int   n_rows;
    int   row_idx;

    // Reference model of the predictor state
    logic                   m_valid [`BTB_WAY][`BTB_SET];
    logic [`BTB_TAG_W-1:0]  m_tag [`BTB_WAY][`BTB_SET];
    bpu_pkg::br_kind_e      m_kind [`BTB_WAY][`BTB_SET];
    logic [`BTB_TGT_W-1:0]  m_tgt [`BTB_WAY][`BTB_SET];
    logic [1:0]             m_ctr [`BHT_ENTRIES];
    logic                   exp_hit;
    logic                   exp_taken;
    logic [`BPU_ADDR_W-1:0] exp_next;

    bpu_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .pc            (pc),
        .update        (update),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_kind   (update_kind),
        .update_target (update_target),
        .pred_hit      (pred_hit),
        .pred_taken    (pred_taken),
        .next_pc       (next_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_row(input logic s, input logic [31:0] p, input logic u,
                           input logic [31:0] upc, input logic t,
                           input bpu_pkg::br_kind_e k, input logic [31:0] tgt);
        rows[n_rows] = {s, p, u, upc, t, k, tgt};
        n_rows++;
    endtask

    task automatic add_lookup(input logic s, input logic [31:0] p);
        add_row(s, p, 1'b0, 32'h0, 1'b0, bpu_pkg::BR_COND, 32'h0);
    endtask

    // Small address pool, two entries alias PC_A and PC_B in bank and set
    function automatic logic [31:0] pick_pc(input logic [2:0] sel);
        case (sel)
            3'd0: return PC_A;
            3'd1: return PC_B;
            3'd2: return PC_C;
            3'd3: return PC_D;
            3'd4: return PC_ALIAS;
            default: return 32'h0000_2010;
        endcase
    endfunction

    ////////////////////////////////////////
    // Reference model

    task automatic model_step();
        logic [1:0] bank_sel;
        logic [5:0] set_sel;
        logic [7:0] ctr_idx;
        logic       hit;
        // Lookup sees the state from before this cycle's training
        if (!cur.stall) begin
            bank_sel  = cur.pc[3:2];
            set_sel   = cur.pc[9:4];
            ctr_idx   = cur.pc[9:2];
            hit       = m_valid[bank_sel][set_sel] && (m_tag[bank_sel][set_sel] == cur.pc[17:10]);
            exp_hit   = hit;
            exp_taken = hit && (m_kind[bank_sel][set_sel] == bpu_pkg::BR_JUMP || m_ctr[ctr_idx][1]);
            exp_next  = exp_taken ? {m_tgt[bank_sel][set_sel], 2'b00} : cur.pc + 32'd4;
        end
        if (cur.update) begin
            bank_sel = cur.update_pc[3:2];
            set_sel  = cur.update_pc[9:4];
            ctr_idx  = cur.update_pc[9:2];
            if (cur.update_taken) begin
                m_valid[bank_sel][set_sel] = 1'b1;
                m_tag[bank_sel][set_sel]   = cur.update_pc[17:10];
                m_kind[bank_sel][set_sel]  = cur.update_kind;
                m_tgt[bank_sel][set_sel]   = cur.update_target[31:2];
            end
            if (cur.update_kind == bpu_pkg::BR_COND) begin
                if (cur.update_taken && m_ctr[ctr_idx] != 2'd3) begin
                    m_ctr[ctr_idx] = m_ctr[ctr_idx] + 2'd1;
                end else if (!cur.update_taken && m_ctr[ctr_idx] != 2'd0) begin
                    m_ctr[ctr_idx] = m_ctr[ctr_idx] - 2'd1;
                end
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s in cycle %0d: got 0x%08h, expected 0x%08h",
                     name, row_idx, actual, expected);
            $display("Test FAILED");
            $fatal(1, "%s differs from the reference model", name);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > RST_TIMEOUT) begin
                $display("Reset was not released within %0d cycles", RST_TIMEOUT);
                $display("Test FAILED");
                $fatal(1, "reset wait timed out");
            end
        end
    endtask

    ////////////////////////////////////////
    // Stimulus table

    task automatic build_table();
        logic [31:0] rnd;
        // Cold tables miss everywhere
        add_lookup(1'b0, PC_A);
        add_lookup(1'b0, PC_C);
        add_lookup(1'b0, PC_ALIAS);
        // Jump install, same cycle lookup still misses
        add_row(1'b0, PC_A, 1'b1, PC_A, 1'b1, bpu_pkg::BR_JUMP, 32'h0000_8000);
        add_lookup(1'b0, PC_A);
        // Counter walk 1, 2, 1, 0, 1, 2, 3, 2
        add_row(1'b0, PC_B, 1'b1, PC_B, 1'b1, bpu_pkg::BR_COND, 32'h0000_9000);
        add_lookup(1'b0, PC_B);
        add_row(1'b0, PC_B, 1'b1, PC_B, 1'b0, bpu_pkg::BR_COND, 32'h0);
        add_row(1'b0, PC_B, 1'b1, PC_B, 1'b0, bpu_pkg::BR_COND, 32'h0);
        add_lookup(1'b0, PC_B);
        repeat (3) add_row(1'b0, PC_B, 1'b1, PC_B, 1'b1, bpu_pkg::BR_COND, 32'h0000_9000);
        add_lookup(1'b0, PC_B);
        add_row(1'b0, PC_B, 1'b1, PC_B, 1'b0, bpu_pkg::BR_COND, 32'h0);
        add_lookup(1'b0, PC_B);
        // Tag alias on a valid entry, then neighbour banks
        add_lookup(1'b0, PC_ALIAS);
        add_row(1'b0, PC_C, 1'b1, PC_C, 1'b1, bpu_pkg::BR_JUMP, 32'h0000_a000);
        add_row(1'b0, PC_D, 1'b1, PC_D, 1'b1, bpu_pkg::BR_COND, 32'h0000_b000);
        add_lookup(1'b0, PC_C);
        add_lookup(1'b0, PC_D);
        add_lookup(1'b0, PC_A);
        // Stall holds outputs while training goes on
        add_row(1'b1, PC_C, 1'b1, PC_A, 1'b1, bpu_pkg::BR_JUMP, 32'h0000_c000);
        add_lookup(1'b1, PC_D);
        add_lookup(1'b1, PC_B);
        add_lookup(1'b0, PC_A);
        for (int i = 0; i < RAND_ROWS; i++) begin
            rnd = $urandom;
            add_row(rnd[1:0] == 2'b00, pick_pc(rnd[7:5]), rnd[2], pick_pc(rnd[10:8]), rnd[3],
                    bpu_pkg::br_kind_e'(rnd[4]), {16'h0000, rnd[31:18], 2'b00});
        end
        // Flush the last lookup
        add_lookup(1'b0, 32'h0);
    endtask

    initial begin
        int unsigned seed_ret;
        seed_ret      = $urandom(79797);
        rst           = 1'b1;
        stall         = 1'b0;
        pc            = '0;
        update        = 1'b0;
        update_pc     = '0;
        update_taken  = 1'b0;
        update_kind   = bpu_pkg::BR_COND;
        update_target = '0;
        cur           = '0;
        n_rows        = 0;
        row_idx       = 0;
        exp_hit       = 1'b0;
        exp_taken     = 1'b0;
        exp_next      = 32'd4;
        for (int b = 0; b < `BTB_WAY; b++) begin
            for (int s = 0; s < `BTB_SET; s++) begin
                m_valid[b][s] = 1'b0;
            end
        end
        for (int i = 0; i < `BHT_ENTRIES; i++) begin
            m_ctr[i] = 2'd1;
        end
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait_reset_release();
        for (row_idx = 0; row_idx < n_rows; row_idx++) begin
            @(posedge clk);
            model_step();
            cur = rows[row_idx];
            stall         <= cur.stall;
            pc            <= cur.pc;
            update        <= cur.update;
            update_pc     <= cur.update_pc;
            update_taken  <= cur.update_taken;
            update_kind   <= cur.update_kind;
            update_target <= cur.update_target;
            @(negedge clk);
            check_value("pred_hit", {31'b0, pred_hit}, {31'b0, exp_hit});
            check_value("pred_taken", {31'b0, pred_taken}, {31'b0, exp_taken});
            check_value("next_pc", next_pc, exp_next);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: source/bpu_top.sv
`timescale 1ns/1ps
`include "bpu_settings.svh"

module bpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic [`BPU_ADDR_W-1:0] pc,
    input  logic                   update,
    input  logic [`BPU_ADDR_W-1:0] update_pc,
    input  logic                   update_taken,
    input  bpu_pkg::br_kind_e      update_kind,
    input  logic [`BPU_ADDR_W-1:0] update_target,
    output logic                   pred_hit,
    output logic                   pred_taken,
    output logic [`BPU_ADDR_W-1:0] next_pc
);

    logic                  entry_valid;
    logic [`BTB_TAG_W-1:0] entry_tag;
    bpu_pkg::br_kind_e     entry_kind;
    logic [`BTB_TGT_W-1:0] entry_target;
    logic                  ctr_taken;

    btb i_btb (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .pc            (pc),
        .update        (update),
        .update_taken  (update_taken),
        .update_pc     (update_pc),
        .update_kind   (update_kind),
        .update_target (update_target),
        .entry_valid   (entry_valid),
        .entry_tag     (entry_tag),
        .entry_kind    (entry_kind),
        .entry_target  (entry_target)
    );

    bimodal_table i_bht (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .pc           (pc),
        .update       (update),
        .update_taken (update_taken),
        .update_pc    (update_pc),
        .update_kind  (update_kind),
        .ctr_taken    (ctr_taken)
    );

    pred_select i_sel (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .pc           (pc),
        .entry_valid  (entry_valid),
        .entry_tag    (entry_tag),
        .entry_kind   (entry_kind),
        .entry_target (entry_target),
        .ctr_taken    (ctr_taken),
        .pred_hit     (pred_hit),
        .pred_taken   (pred_taken),
        .next_pc      (next_pc)
    );

endmodule

// File: source/pred_select.sv
`timescale 1ns/1ps
`include "bpu_settings.svh"

module pred_select (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic [`BPU_ADDR_W-1:0] pc,
    input  logic                   entry_valid,
    input  logic [`BTB_TAG_W-1:0]  entry_tag,
    input  bpu_pkg::br_kind_e      entry_kind,
    input  logic [`BTB_TGT_W-1:0]  entry_target,
    input  logic                   ctr_taken,
    output logic                   pred_hit,
    output logic                   pred_taken,
    output logic [`BPU_ADDR_W-1:0] next_pc
);

    logic [`BPU_ADDR_W-1:0] s2_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_pc <= '0;
        end else if (!stall) begin
            s2_pc <= pc;
        end
    end

    ////////////////////////////////////////
    // Tag compare and direction

    assign pred_hit = entry_valid &&
                      (entry_tag == s2_pc[`BTB_TAG_LO+`BTB_TAG_W-1:`BTB_TAG_LO]);

    // Jumps ignore the counter
    assign pred_taken = pred_hit && (entry_kind == bpu_pkg::BR_JUMP || ctr_taken);

    assign next_pc = pred_taken ? {entry_target, 2'b00} : s2_pc + `BPU_ADDR_W'(4);

    a_taken_needs_hit: assert property (
        @(posedge clk) disable iff (rst) pred_taken |-> pred_hit
    );

    // Lookup outputs hold while stalled, training still runs
    a_stall_holds: assert property (
        @(posedge clk) disable iff (rst)
        ($past(stall) && !$past(rst)) |-> ($stable(next_pc) && $stable(pred_hit))
    );

endmodule

// File: source/bimodal_table.sv
`timescale 1ns/1ps
`include "bpu_settings.svh"

module bimodal_table (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic [`BPU_ADDR_W-1:0] pc,
    input  logic                   update,
    input  logic                   update_taken,
    input  logic [`BPU_ADDR_W-1:0] update_pc,
    input  bpu_pkg::br_kind_e      update_kind,
    output logic                   ctr_taken
);

    logic [1:0]            ctr [`BHT_ENTRIES];
    logic [`BHT_IDX_W-1:0] rd_idx;
    logic [`BHT_IDX_W-1:0] up_idx;
    logic [1:0]            up_cur;
    logic [1:0]            up_next;

    assign rd_idx = pc[`BHT_IDX_W+1:2];
    assign up_idx = update_pc[`BHT_IDX_W+1:2];

    ////////////////////////////////////////
    // Saturating counter step

    always_comb begin
        up_cur  = ctr[up_idx];
        up_next = up_cur;
        if (update_taken && up_cur != 2'd3) begin
            up_next = up_cur + 2'd1;
        end else if (!update_taken && up_cur != 2'd0) begin
            up_next = up_cur - 2'd1;
        end
    end

    // All counters start weakly not taken
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                ctr[i] <= 2'd1;
            end
            ctr_taken <= 1'b0;
        end else begin
            if (!stall) begin
                ctr_taken <= ctr[rd_idx][1];
            end
            if (update && update_kind == bpu_pkg::BR_COND) begin
                ctr[up_idx] <= up_next;
            end
        end
    end

    a_update_aligned: assert property (
        @(posedge clk) disable iff (rst) update |-> (update_pc[1:0] == 2'b00)
    );

endmodule

// File: source/btb.sv
`timescale 1ns/1ps
`include "bpu_settings.svh"

module btb (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic [`BPU_ADDR_W-1:0] pc,
    input  logic                   update,
    input  logic                   update_taken,
    input  logic [`BPU_ADDR_W-1:0] update_pc,
    input  bpu_pkg::br_kind_e      update_kind,
    input  logic [`BPU_ADDR_W-1:0] update_target,
    output logic                   entry_valid,
    output logic [`BTB_TAG_W-1:0]  entry_tag,
    output bpu_pkg::br_kind_e      entry_kind,
    output logic [`BTB_TGT_W-1:0]  entry_target
);

    logic [`BTB_BANK_W-1:0]  rd_bank;
    logic [`BTB_BANK_W-1:0]  wr_bank;
    logic [`BTB_BANK_W-1:0]  s2_bank;
    logic [`BTB_SET_W-1:0]   rd_set;
    logic [`BTB_SET_W-1:0]   wr_set;
    logic [`BTB_ENTRY_W-1:0] wr_word;
    logic [`BTB_ENTRY_W-1:0] s2_word;
    logic [`BTB_WAY-1:0]     bank_ren;
    logic [`BTB_WAY-1:0]     bank_we;
    logic [`BTB_WAY-1:0]     bank_rvalid;
    logic [`BTB_ENTRY_W-1:0] bank_rdata [`BTB_WAY];

    ////////////////////////////////////////
    // Field split and bank decode

    assign rd_bank = pc[`BTB_SET_LO-1:2];
    assign wr_bank = update_pc[`BTB_SET_LO-1:2];
    assign rd_set  = pc[`BTB_TAG_LO-1:`BTB_SET_LO];
    assign wr_set  = update_pc[`BTB_TAG_LO-1:`BTB_SET_LO];

    // Word layout is tag, kind, target
    assign wr_word = {update_pc[`BTB_TAG_LO+`BTB_TAG_W-1:`BTB_TAG_LO], update_kind,
                      update_target[`BPU_ADDR_W-1:2]};

    always_comb begin
        for (int i = 0; i < `BTB_WAY; i++) begin
            bank_ren[i] = !stall && (rd_bank == `BTB_BANK_W'(i));
            bank_we[i]  = update && update_taken && (wr_bank == `BTB_BANK_W'(i));
        end
    end

    for (genvar i = 0; i < `BTB_WAY; i++) begin : g_bank
        btb_bank_ram i_ram (
            .clk    (clk),
            .rst    (rst),
            .en     (bank_ren[i]),
            .we     (bank_we[i]),
            .waddr  (wr_set),
            .raddr  (rd_set),
            .wdata  (wr_word),
            .rdata  (bank_rdata[i]),
            .rvalid (bank_rvalid[i])
        );
    end

    ////////////////////////////////////////
    // Stage 2 bank select

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_bank <= '0;
        end else if (!stall) begin
            s2_bank <= rd_bank;
        end
    end

    assign s2_word      = bank_rdata[s2_bank];
    assign entry_valid  = bank_rvalid[s2_bank];
    assign entry_tag    = s2_word[`BTB_ENTRY_W-1 -: `BTB_TAG_W];
    assign entry_kind   = bpu_pkg::br_kind_e'(s2_word[`BTB_TGT_W]);
    assign entry_target = s2_word[`BTB_TGT_W-1:0];

    a_one_bank_write: assert property (
        @(posedge clk) disable iff (rst) $onehot0(bank_we)
    );

endmodule

// File: source/btb_bank_ram.sv
`timescale 1ns/1ps
`include "bpu_settings.svh"

module btb_bank_ram (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    en,
    input  logic                    we,
    input  logic [`BTB_SET_W-1:0]   waddr,
    input  logic [`BTB_SET_W-1:0]   raddr,
    input  logic [`BTB_ENTRY_W-1:0] wdata,
    output logic [`BTB_ENTRY_W-1:0] rdata,
    output logic                    rvalid
);

    logic [`BTB_ENTRY_W-1:0] mem [`BTB_SET];
    logic [`BTB_SET-1:0]     valid;

    ////////////////////////////////////////
    // Write port

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (we) begin
            valid[waddr] <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Registered read, old data on collision

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata  <= '0;
            rvalid <= 1'b0;
        end else if (en) begin
            rdata  <= mem[raddr];
            rvalid <= valid[raddr];
        end
    end

    // Valid bit must never leak X into the hit logic
    a_rvalid_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(rvalid)
    );

endmodule

// File: source/bpu_pkg.sv
package bpu_pkg;

    // Branch kind stored with each target buffer entry
    typedef enum logic {
        BR_COND = 1'b0,
        BR_JUMP = 1'b1
    } br_kind_e;

endpackage

// File: source/bpu_settings.svh
`ifndef BPU_SETTINGS_SVH
`define BPU_SETTINGS_SVH

// Fetch address width
`define BPU_ADDR_W 32

// Target buffer geometry
`define BTB_WAY 4
`define BTB_SET 64
`define BTB_TAG_W 8
`define BTB_TGT_W 30

// Direction counters
`define BHT_ENTRIES 256

// Derived field widths and positions within the pc
`define BTB_BANK_W ($clog2(`BTB_WAY))
`define BTB_SET_W ($clog2(`BTB_SET))
`define BTB_SET_LO (2 + `BTB_BANK_W)
`define BTB_TAG_LO (`BTB_SET_LO + `BTB_SET_W)
`define BTB_ENTRY_W (`BTB_TAG_W + 1 + `BTB_TGT_W)
`define BHT_IDX_W ($clog2(`BHT_ENTRIES))

`endif
